//--- design/sdr_bit_scan.sv
// #########################################################################
// Execute stage that walks a copy of the register word by word and
// emits the lowest set bit of the current word each cycle.
// #########################################################################

`default_nettype none

`include "sdr_consts.svh"

module sdr_bit_scan (
	input  wire logic                   sdr_control,
	input  wire logic                   rst_n,
	input  wire sdr_scan_pkg::sdr_ctl_t ctl,
	input  wire sdr_reg_pkg::sdr_data_t sdr_reg,
	output sdr_scan_pkg::sdr_hit_t      hit,
	output sdr_scan_pkg::sdr_scan_t     scan,
	output logic [5:0]                  shift_counter
);

	import sdr_reg_pkg::*;

	localparam int BIT_W = $clog2(`SDR_WORD_W);
	localparam int PTR_W = $clog2(`SDR_WORDS) + 1; // one past the last word.

	sdr_data_t              work;
	logic [PTR_W-1:0]       ptr;
	logic                   busy;
	logic                   done;
	logic                   hit_valid;
	logic [`SDR_IDX_W-1:0]  hit_idx;
	logic [`SDR_WORD_W-1:0] cur_word;
	logic [BIT_W-1:0]       lsb;
	logic                   word_set;
	logic                   last_word;

	assign cur_word  = work[ptr[PTR_W-2:0]];
	assign word_set  = (cur_word != '0);
	assign last_word = (ptr == PTR_W'(`SDR_WORDS - 1));

	// priority search where the lowest position wins.
	always_comb begin
		lsb = '0;
		for (int i = `SDR_WORD_W - 1; i >= 0; i--) begin
			if (cur_word[i])
				lsb = BIT_W'(i);
		end
	end

	always_ff @(posedge sdr_control) begin
		if (!rst_n) begin
			ptr       <= '0;
			busy      <= 1'b0;
			done      <= 1'b0;
			hit_valid <= 1'b0;
		end else begin
			done      <= 1'b0;
			hit_valid <= 1'b0;
			if (!busy) begin
				if (ctl.start) begin
					ptr  <= '0;
					busy <= 1'b1;
				end else if (ctl.clear) begin
					ptr <= '0;
				end
			end else if (word_set) begin
				hit_valid <= 1'b1;
			end else begin
				ptr <= ptr + 1'b1;
				if (last_word) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sdr_control) begin
		if (!busy && ctl.start)
			work <= sdr_reg;
		else if (busy && word_set)
			work[ptr[PTR_W-2:0]] <= cur_word & (cur_word - 1'b1); // drop lowest bit.
		hit_idx <= `SDR_IDX_W'({ptr[PTR_W-2:0], lsb});
	end

	assign hit           = '{valid: hit_valid, idx: hit_idx};
	assign scan          = '{busy: busy, done: done};
	assign shift_counter = ptr;

	// a hit only comes out of a running scan.
	a_hit_in_scan: assert property (@(posedge sdr_control) disable iff (!rst_n)
		hit.valid |-> scan.busy);

	// done only after the pointer stepped past word 31.
	a_done_at_end: assert property (@(posedge sdr_control) disable iff (!rst_n)
		scan.done |-> (shift_counter == PTR_W'(`SDR_WORDS)) && !scan.busy);

endmodule

`default_nettype wire

//--- design/sdr_cmd_decode.sv
// #########################################################################
// Command decode that turns rising edges of the start and clear bits
// into registered one cycle pulses.
// #########################################################################

`default_nettype none

`include "sdr_consts.svh"

module sdr_cmd_decode (
	input  wire logic                   sdr_control,
	input  wire logic                   rst_n,
	input  wire logic [`SDR_WORD_W-1:0] sdr_cmd,
	output sdr_scan_pkg::sdr_ctl_t      ctl
);

	logic [1:0] cmd_q; // {clear, start} at the last clock.
	logic       start_rise;
	logic       clear_rise;

	assign start_rise = sdr_cmd[`SDR_CMD_START] & ~cmd_q[0];
	assign clear_rise = sdr_cmd[`SDR_CMD_CLEAR] & ~cmd_q[1];

	always_ff @(posedge sdr_control) begin
		if (!rst_n) begin
			cmd_q     <= '0;
			ctl.start <= 1'b0;
			ctl.clear <= 1'b0;
		end else begin
			cmd_q     <= {sdr_cmd[`SDR_CMD_CLEAR], sdr_cmd[`SDR_CMD_START]};
			ctl.start <= start_rise;
			// start wins when both rise together.
			ctl.clear <= clear_rise & ~start_rise;
		end
	end

endmodule

`default_nettype wire

//--- design/sdr_consts.svh
// #########################################################################
// Sizes of the scanned register and the index array, and the command
// word bit positions.
// #########################################################################

`ifndef SDR_CONSTS_SVH
`define SDR_CONSTS_SVH

// data register geometry.
`define SDR_WORDS     32
`define SDR_WORD_W    32

// one stored bit number.
`define SDR_IDX_W     16
`define SDR_MAX_IDX   31

// command word bits.
`define SDR_CMD_START 0
`define SDR_CMD_CLEAR 1

`endif

//--- design/sdr_index_result.sv
// #########################################################################
// Result stage that packs hit indexes into the index array, counts set
// bits and keeps the status word.
// #########################################################################

`default_nettype none

`include "sdr_consts.svh"

module sdr_index_result (
	input  wire logic                    sdr_control,
	input  wire logic                    rst_n,
	input  wire sdr_scan_pkg::sdr_ctl_t  ctl,
	input  wire sdr_scan_pkg::sdr_hit_t  hit,
	input  wire sdr_scan_pkg::sdr_scan_t scan,
	output sdr_reg_pkg::sdr_index_t      sdr_index,
	output sdr_reg_pkg::sdr_status_t     sdr_status
);

	localparam int SLOT_W = $clog2(`SDR_MAX_IDX + 1);

	logic              wipe;
	logic              room;
	logic [SLOT_W-1:0] slot;

	// start or clear only between scans.
	assign wipe = (ctl.start | ctl.clear) & ~scan.busy;
	assign room = (sdr_status.count < 8'(`SDR_MAX_IDX));
	assign slot = sdr_status.count[SLOT_W-1:0];

	always_ff @(posedge sdr_control) begin
		if (!rst_n) begin
			sdr_index <= '0;
		end else if (wipe) begin
			sdr_index <= '0;
		end else if (hit.valid && room) begin
			if (slot[0])
				sdr_index[slot[SLOT_W-1:1]][`SDR_WORD_W-1:`SDR_IDX_W] <= hit.idx;
			else
				sdr_index[slot[SLOT_W-1:1]][`SDR_IDX_W-1:0] <= hit.idx; // even slot low.
		end
	end

	always_ff @(posedge sdr_control) begin
		if (!rst_n) begin
			sdr_status <= '0;
		end else if (wipe) begin
			sdr_status <= '0;
		end else begin
			sdr_status.busy <= scan.busy;
			if (scan.done)
				sdr_status.done <= 1'b1; // held until the next start or clear.
			if (hit.valid) begin
				sdr_status.total <= sdr_status.total + 1'b1;
				if (room)
					sdr_status.count <= sdr_status.count + 1'b1;
				else
					sdr_status.overflow <= 1'b1;
			end
		end
	end

	// count stops at 31 while total keeps running.
	a_count_sat: assert property (@(posedge sdr_control) disable iff (!rst_n)
		(sdr_status.count <= 8'(`SDR_MAX_IDX)) &&
		(sdr_status.total >= 17'(sdr_status.count)));

endmodule

`default_nettype wire

//--- design/sdr_reg_pkg.sv
// #########################################################################
// Data register, index array and status word types as seen from
// outside the scanner.
// #########################################################################

`default_nettype none

`include "sdr_consts.svh"

package sdr_reg_pkg;

	// word 0 first. bit y of word z is bit number y + 32*z.
	typedef logic [0:`SDR_WORDS-1][`SDR_WORD_W-1:0] sdr_data_t;

	// two indexes per word with the even slot in the low half.
	typedef logic [0:(`SDR_MAX_IDX+1)/2-1][`SDR_WORD_W-1:0] sdr_index_t;

	typedef struct packed {
		logic        done;     // bit 31.
		logic        busy;     // bit 30.
		logic        overflow; // more than 31 bits set.
		logic [3:0]  rsvd;
		logic [16:0] total;    // every set bit in bits 24:8.
		logic [7:0]  count;    // stored indexes up to 31.
	} sdr_status_t;

endpackage

`default_nettype wire

//--- design/sdr_scan_pkg.sv
// #########################################################################
// Pulses, hits and scan state passed between the scan stages.
// #########################################################################

`default_nettype none

`include "sdr_consts.svh"

package sdr_scan_pkg;

	// single cycle command pulses.
	typedef struct packed {
		logic start;
		logic clear;
	} sdr_ctl_t;

	// one set bit found.
	typedef struct packed {
		logic                  valid;
		logic [`SDR_IDX_W-1:0] idx;
	} sdr_hit_t;

	typedef struct packed {
		logic busy; // level for the whole scan.
		logic done; // one cycle after the last word.
	} sdr_scan_t;

endpackage

`default_nettype wire

//--- design/sdr_scan_top.sv
// #########################################################################
// Scanner top level with the command decode, bit scan and result stages.
// #########################################################################

`default_nettype none

`include "sdr_consts.svh"

module sdr_scan_top (
	input  wire logic                   sdr_control,
	input  wire logic                   rst_n,
	input  wire logic [`SDR_WORD_W-1:0] sdr_cmd,
	input  wire sdr_reg_pkg::sdr_data_t sdr_reg,
	output sdr_reg_pkg::sdr_index_t     sdr_index,
	output sdr_reg_pkg::sdr_status_t    sdr_status,
	output logic [5:0]                  shift_counter
);

	import sdr_scan_pkg::*;

	wire sdr_ctl_t  ctl;  // start and clear pulses.
	wire sdr_hit_t  hit;
	wire sdr_scan_t scan;

	sdr_cmd_decode u_decode (
		.sdr_control (sdr_control),
		.rst_n       (rst_n),
		.sdr_cmd     (sdr_cmd),
		.ctl         (ctl)
	);

	sdr_bit_scan u_scan (
		.sdr_control   (sdr_control),
		.rst_n         (rst_n),
		.ctl           (ctl),
		.sdr_reg       (sdr_reg),
		.hit           (hit),
		.scan          (scan),
		.shift_counter (shift_counter)
	);

	sdr_index_result u_result (
		.sdr_control (sdr_control),
		.rst_n       (rst_n),
		.ctl         (ctl),
		.hit         (hit),
		.scan        (scan),
		.sdr_index   (sdr_index),
		.sdr_status  (sdr_status)
	);

endmodule

`default_nettype wire

//--- sdr_scan_top.f
+incdir+design/
+incdir+sim/
design/sdr_reg_pkg.sv
design/sdr_scan_pkg.sv
design/sdr_cmd_decode.sv
design/sdr_bit_scan.sv
design/sdr_index_result.sv
design/sdr_scan_top.sv
sim/tb_sdr_scan.sv

//--- sim/tb_sdr_model.svh
// #########################################################################
// Reference model for the expected index array and status word of a
// finished scan, found by walking the register one bit at a time.
// #########################################################################

`ifndef TB_SDR_MODEL_SVH
`define TB_SDR_MODEL_SVH

// set bits over all 1024 positions.
function automatic int count_set_bits(input sdr_data_t v);
	int n;
	n = 0;
	for (int b = 0; b < `SDR_WORDS * `SDR_WORD_W; b++) begin
		if (v[b / `SDR_WORD_W][b % `SDR_WORD_W])
			n++;
	end
	return n;
endfunction

// first 31 bit numbers in ascending order with two per word.
function automatic sdr_index_t ascending_indexes(input sdr_data_t v);
	sdr_index_t idx;
	int         stored;
	idx    = '0;
	stored = 0;
	for (int b = 0; b < `SDR_WORDS * `SDR_WORD_W; b++) begin
		if (v[b / `SDR_WORD_W][b % `SDR_WORD_W] && stored < `SDR_MAX_IDX) begin
			idx[stored / 2][(stored % 2) * `SDR_IDX_W +: `SDR_IDX_W] = `SDR_IDX_W'(b);
			stored++;
		end
	end
	return idx;
endfunction

// status once done is set. busy is low by then.
function automatic sdr_status_t finished_status(input sdr_data_t v);
	sdr_status_t s;
	int          total;
	total      = count_set_bits(v);
	s          = '0;
	s.done     = 1'b1;
	s.overflow = (total > `SDR_MAX_IDX);
	s.total    = 17'(total);
	s.count    = (total > `SDR_MAX_IDX) ? 8'(`SDR_MAX_IDX) : 8'(total);
	return s;
endfunction

`endif

//--- sim/tb_sdr_scan.sv
// #########################################################################
// Testbench for the scanner top level with reset values, directed and
// random register values against the reference model, start and clear.
// #########################################################################

`default_nettype none

`include "sdr_consts.svh"

module tb_sdr_scan;

	import sdr_reg_pkg::*;

	`include "tb_sdr_model.svh"

	localparam int CLK_HALF    = 4;
	localparam int BUSY_LIMIT  = 10;
	localparam int DONE_LIMIT  = 2000;
	localparam int CLEAR_LIMIT = 10;
	localparam int N_RANDOM    = 40;

	logic                   sdr_control;
	logic                   rst_n;
	logic [`SDR_WORD_W-1:0] sdr_cmd;
	sdr_data_t              sdr_reg;
	sdr_index_t             sdr_index;
	sdr_status_t            sdr_status;
	logic [5:0]             shift_counter;

	int        errors;
	int        scans;
	int        nbits;
	bit        run_ok;
	sdr_data_t vec;
	sdr_data_t other;

	sdr_scan_top u_dut (
		.sdr_control   (sdr_control),
		.rst_n         (rst_n),
		.sdr_cmd       (sdr_cmd),
		.sdr_reg       (sdr_reg),
		.sdr_index     (sdr_index),
		.sdr_status    (sdr_status),
		.shift_counter (shift_counter)
	);

	initial begin
		sdr_control = 1'b0;
		forever #CLK_HALF sdr_control = ~sdr_control;
	end

	task automatic log_error(input string msg);
		errors++;
		$display("ERR @%0t: %s", $time, msg);
	endtask

	a_done_idle: assert property (@(posedge sdr_control) disable iff (!rst_n)
		sdr_status.done |-> !sdr_status.busy)
		else log_error("done and busy set together");

	// busy only drops at the end of a scan.
	a_busy_end: assert property (@(posedge sdr_control) disable iff (!rst_n)
		$fell(sdr_status.busy) |-> sdr_status.done)
		else log_error("busy fell without done");

	a_count_total: assert property (@(posedge sdr_control) disable iff (!rst_n)
		(sdr_status.overflow == (sdr_status.total > 17'(`SDR_MAX_IDX))) &&
		(sdr_status.count == ((sdr_status.total > 17'(`SDR_MAX_IDX)) ?
			8'(`SDR_MAX_IDX) : sdr_status.total[7:0])))
		else log_error("count, total and overflow disagree");

	task automatic pulse_cmd(input int pos);
		@(posedge sdr_control);
		sdr_cmd[pos] <= 1'b1;
		@(posedge sdr_control);
		sdr_cmd <= '0;
	endtask

	task automatic start_scan(input sdr_data_t v);
		@(posedge sdr_control);
		sdr_reg <= v;
		pulse_cmd(`SDR_CMD_START);
	endtask

	task automatic wait_busy(output bit ok);
		int n;
		n = 0;
		@(negedge sdr_control);
		while (!sdr_status.busy && n < BUSY_LIMIT) begin
			n++;
			@(negedge sdr_control);
		end
		ok = sdr_status.busy;
		if (!ok)
			$display("scan never started after the start command");
	endtask

	task automatic wait_done(output bit ok);
		int n;
		n = 0;
		@(negedge sdr_control);
		while (!sdr_status.done && n < DONE_LIMIT) begin
			a_busy_in_scan: assert (sdr_status.busy)
				else log_error("busy low before done");
			n++;
			@(negedge sdr_control);
		end
		ok = sdr_status.done;
		if (!ok)
			$display("scan never finished within 2000 cycles");
	endtask

	task automatic check_result(input sdr_data_t v);
		sdr_status_t exp_status;
		sdr_index_t  exp_index;
		exp_status = finished_status(v);
		exp_index  = ascending_indexes(v);
		a_status: assert (sdr_status == exp_status)
			else log_error($sformatf("status %h, expected %h", sdr_status, exp_status));
		for (int w = 0; w < (`SDR_MAX_IDX + 1) / 2; w++) begin
			a_slot: assert (sdr_index[w] == exp_index[w])
				else log_error($sformatf("index word %0d is %h, expected %h",
					w, sdr_index[w], exp_index[w]));
		end
		a_ptr_end: assert (shift_counter == 6'(`SDR_WORDS))
			else log_error($sformatf("shift_counter %0d at done", shift_counter));
	endtask

	task automatic scan_and_check(input sdr_data_t v, output bit ok);
		start_scan(v);
		wait_busy(ok);
		if (ok)
			wait_done(ok);
		if (ok) begin
			check_result(v);
			scans++;
		end
	endtask

	// scattered positions where repeats may fall on one bit.
	function automatic sdr_data_t random_vector(input int count);
		sdr_data_t v;
		int        pos;
		v = '0;
		for (int i = 0; i < count; i++) begin
			pos = $urandom_range(`SDR_WORDS * `SDR_WORD_W - 1, 0);
			v[pos / `SDR_WORD_W][pos % `SDR_WORD_W] = 1'b1;
		end
		return v;
	endfunction

	// the whole test sequence up to the first timeout.
	task automatic run_tests(output bit ok);
		@(negedge sdr_control);
		a_reset: assert (sdr_status == '0 && sdr_index == '0 && shift_counter == '0)
			else log_error("outputs not zero after reset");

		vec    = '0;
		vec[0] = 32'h0000_ffff;
		scan_and_check(vec, ok);
		if (!ok)
			return;

		vec         = '0;
		vec[0][3]   = 1'b1;
		vec[5][17]  = 1'b1;
		vec[12][31] = 1'b1;
		vec[20][0]  = 1'b1;
		vec[31][0]  = 1'b1;
		vec[31][31] = 1'b1;
		scan_and_check(vec, ok);
		if (!ok)
			return;

		vec     = '0; // 66 bits so the count saturates.
		vec[7]  = '1;
		vec[8]  = '1;
		vec[31] = 32'h8000_0001;
		scan_and_check(vec, ok);
		if (!ok)
			return;

		// restart attempt in the middle of a scan.
		vec   = random_vector(20);
		other = random_vector(5);
		start_scan(vec);
		wait_busy(ok);
		if (!ok)
			return;
		@(posedge sdr_control);
		sdr_reg <= other;
		pulse_cmd(`SDR_CMD_START);
		wait_done(ok);
		if (!ok)
			return;
		check_result(vec);
		scans++;

		pulse_cmd(`SDR_CMD_CLEAR);
		for (int n = 0; n < CLEAR_LIMIT && sdr_status.done; n++)
			@(negedge sdr_control);
		ok = !sdr_status.done;
		if (!ok) begin
			$display("clear while idle never reset the status word");
			return;
		end
		a_cleared: assert (sdr_status == '0 && sdr_index == '0)
			else log_error("status or index not zero after clear");

		for (int i = 0; i < N_RANDOM; i++) begin
			nbits = (i % 5 == 4) ? $urandom_range(40, 30) : $urandom_range(40, 0);
			scan_and_check(random_vector(nbits), ok);
			if (!ok)
				return;
		end
	endtask

	initial begin
		void'($urandom(32'hcb65_c1fd));
		rst_n   = 1'b0;
		sdr_cmd = '0;
		sdr_reg = '0;
		errors  = 0;
		scans   = 0;
		repeat (3) @(posedge sdr_control);
		rst_n <= 1'b1;

		run_tests(run_ok);

		$display("scans %0d, errors %0d", scans, errors);
		if (run_ok && errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
